/* source/frame_pkg.sv */
//**********************************************************
// Shared vector types, OSD status bit map and crop constants
// for the frame wrapper glue logic
//**********************************************************
package frame_pkg;

    // Vector types with a meaning
    typedef logic [63:0]        status_t;
    typedef logic [6:0]         core_mod_t;
    typedef logic [6:0]         user_pin_t;
    typedef logic [24:0]        mouse_pkt_t;
    typedef logic signed [8:0]  mouse_delta_t;
    typedef logic [7:0]         mouse_flags_t;
    typedef logic [11:0]        hdmi_dim_t;
    typedef logic [11:0]        crop_size_t;
    typedef logic signed [4:0]  crop_off_t;
    typedef logic [2:0]         crop_scale_t;
    typedef logic [3:0]         vcopt_t;
    typedef logic [15:0]        menumask_t;

    // Status word bit positions
    localparam int ST_SCANLINE_LO  = 3;
    localparam int ST_SCANLINE_HI  = 5;
    localparam int ST_60HZ         = 19;
    localparam int ST_DB15         = 37;
    localparam int ST_UART         = 38;
    // Flip code overlaps the UART enable bit
    localparam int ST_FLIP_LO      = 38;
    localparam int ST_CROP_EN      = 41;
    localparam int ST_VCOPT_LO     = 42;
    localparam int ST_SCALE_LO     = 46;
    localparam int ST_HSIZE_EN     = 48;
    localparam int ST_HSIZE_LO     = 49;
    // Horizontal offset, then vertical offset just above it
    localparam int ST_OFFSET_LO    = 53;
    localparam int ST_FORCE_SCAN2X = 63;

    // Vertical crop for 1080p output
    localparam hdmi_dim_t  HDMI_FULL_W = 12'd1920;
    localparam hdmi_dim_t  HDMI_FULL_H = 12'd1080;
    localparam crop_size_t CROP_LINES  = 12'd216;
    // Option value where the offset wraps to negative
    localparam vcopt_t     VCOPT_WRAP  = 4'd6;

endpackage

/* source/osd_config.sv */
//**********************************************************
// Splits the OSD status word into named fields, builds the
// menu-hiding mask and registers the framebuffer flip flag
//**********************************************************
`timescale 1ns/1ps

module osd_config #(
    parameter bit ROTATE_MENU = 1'b0,
    parameter bit OSD_60HZ    = 1'b0
) (
    input  logic                   clk_sys,
    input  logic                   rst,
    input  frame_pkg::status_t     status,
    input  frame_pkg::core_mod_t   core_mod,
    input  logic                   direct_video,
    input  logic                   crop_ok,
    output frame_pkg::menumask_t   menumask,
    output logic                   framebuf_flip,
    output logic                   db15_en,
    output logic                   uart_en,
    output logic                   crop_en,
    output frame_pkg::vcopt_t      vcopt,
    output frame_pkg::crop_scale_t crop_scale,
    output logic                   scanline_fx,
    output logic                   force_scan2x,
    output logic                   hsize_enable,
    output logic [3:0]             hsize_scale,
    output logic [3:0]             hoffset,
    output logic [3:0]             voffset
);
    import frame_pkg::*;

    // Plain field decode
    assign db15_en      = status[ST_DB15];
    assign uart_en      = status[ST_UART];
    assign crop_en      = status[ST_CROP_EN];
    assign vcopt        = status[ST_VCOPT_LO +: $bits(vcopt_t)];
    assign crop_scale   = {1'b0, status[ST_SCALE_LO +: 2]};
    assign scanline_fx  = status[ST_SCANLINE_HI:ST_SCANLINE_LO] != '0;
    assign force_scan2x = status[ST_FORCE_SCAN2X];
    assign hsize_enable = status[ST_HSIZE_EN];
    assign hsize_scale  = status[ST_HSIZE_LO +: 4];
    assign hoffset      = status[ST_OFFSET_LO +: 4];
    assign voffset      = status[ST_OFFSET_LO + 4 +: 4];

    // High bit hides the menu entry
    assign menumask[15:6] = '0;
    assign menumask[5]    = crop_ok;
    assign menumask[4]    = ROTATE_MENU ? ~core_mod[0] : 1'b1;
    assign menumask[3]    = OSD_60HZ ? status[ST_60HZ] : 1'b1;
    assign menumask[2]    = ~hsize_enable;
    // Vertical games only
    assign menumask[1]    = ROTATE_MENU ? 1'b1 : ~core_mod[0];
    assign menumask[0]    = direct_video;

    // Flip code 2'b10 selects a flipped framebuffer
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            framebuf_flip <= 1'b0;
        end else begin
            framebuf_flip <= status[ST_FLIP_LO +: 2] == 2'b10;
        end
    end

endmodule

/* source/user_port.sv */
//**********************************************************
// Drives the user extension port for the DB15 adapter or
// the UART, and returns the UART receive line to the core
//**********************************************************
`timescale 1ns/1ps

module user_port (
    input  logic                 clk_sys,
    input  logic                 rst,
    input  logic                 db15_en,
    input  logic                 uart_en,
    input  frame_pkg::user_pin_t user_in,
    input  frame_pkg::user_pin_t joy_out,
    input  logic                 game_tx,
    input  logic                 uart_tx,
    output frame_pkg::user_pin_t user_out,
    output logic                 game_rx
);
    import frame_pkg::*;

    // Pin 0 transmits and pin 1 receives in UART mode
    localparam int UART_RX_PIN = 1;

    user_pin_t port_nxt;

    // DB15 adapter has priority over the UART
    always_comb begin
        if (db15_en) begin
            port_nxt = joy_out;
        end else if (uart_en) begin
            // Both transmitters share the line, low wins
            port_nxt = {6'h3f, game_tx & uart_tx};
        end else begin
            port_nxt = '1;
        end
    end

    // Idle port is all ones
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            user_out <= '1;
        end else begin
            user_out <= port_nxt;
        end
    end

    // Receive line idles high while the UART is off
    assign game_rx = uart_en ? user_in[UART_RX_PIN] : 1'b1;

endmodule

/* source/mouse_decode.sv */
//**********************************************************
// Detects new host mouse packets by their toggle bit and
// presents sign-extended movement with a one-cycle strobe
//**********************************************************
`timescale 1ns/1ps

module mouse_decode (
    input  logic                    clk_sys,
    input  logic                    rst,
    input  frame_pkg::mouse_pkt_t   ps2_mouse,
    output logic                    mouse_st,
    output frame_pkg::mouse_delta_t mouse_dx,
    output frame_pkg::mouse_delta_t mouse_dy,
    output frame_pkg::mouse_flags_t mouse_flags
);
    import frame_pkg::*;

    localparam int TOGGLE_BIT = 24;
    localparam int X_SIGN_BIT = 4;
    localparam int Y_SIGN_BIT = 5;

    mouse_pkt_t pkt_r;
    logic       toggle_l;
    logic       new_pkt;

    // Input capture and previous toggle
    always_ff @(posedge clk_sys) begin
        pkt_r    <= ps2_mouse;
        toggle_l <= pkt_r[TOGGLE_BIT];
    end

    assign new_pkt = pkt_r[TOGGLE_BIT] ^ toggle_l;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            mouse_st <= 1'b0;
        end else begin
            mouse_st <= new_pkt;
        end
    end

    // Movement holds until the next packet
    always_ff @(posedge clk_sys) begin
        if (new_pkt) begin
            mouse_flags <= pkt_r[7:0];
            mouse_dx    <= {pkt_r[X_SIGN_BIT], pkt_r[15:8]};
            mouse_dy    <= {pkt_r[Y_SIGN_BIT], pkt_r[23:16]};
        end
    end

endmodule

/* source/crop_ctrl.sv */
//**********************************************************
// Vertical crop control for 1080p output: checks that the
// video settings allow cropping, sets crop size and offset
//**********************************************************
`timescale 1ns/1ps

module crop_ctrl (
    input  logic                   clk_sys,
    input  logic                   rst,
    input  frame_pkg::hdmi_dim_t   hdmi_width,
    input  frame_pkg::hdmi_dim_t   hdmi_height,
    input  logic                   scanline_fx,
    input  logic                   force_scan2x,
    input  frame_pkg::crop_scale_t crop_scale,
    input  logic                   direct_video,
    input  logic [1:0]             osd_rotate,
    input  logic                   crop_en,
    input  frame_pkg::vcopt_t      vcopt,
    output logic                   crop_ok,
    output frame_pkg::crop_size_t  crop_size,
    output frame_pkg::crop_off_t   crop_off
);
    import frame_pkg::*;

    // Subtracted at the wrap point, giving -12..+6 lines
    localparam crop_off_t OFF_WRAP_SUB = 5'd24;

    logic      full_hd;
    logic      plain_video;
    crop_off_t off_base;
    crop_off_t off_nxt;

    assign full_hd = (hdmi_width == HDMI_FULL_W) && (hdmi_height == HDMI_FULL_H);

    // No scan effects, scaling, direct video or rotation
    assign plain_video = !scanline_fx && !force_scan2x && (crop_scale == '0)
                         && !direct_video && !osd_rotate[0];

    assign off_base = {vcopt, 1'b0};

    always_comb begin
        if (vcopt < VCOPT_WRAP) begin
            off_nxt = off_base;
        end else begin
            off_nxt = off_base - OFF_WRAP_SUB;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            crop_ok  <= 1'b0;
            crop_off <= '0;
        end else begin
            crop_ok  <= full_hd && plain_video;
            crop_off <= off_nxt;
        end
    end

    // Follows the registered crop_ok, so one cycle behind it
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            crop_size <= '0;
        end else if (crop_ok && crop_en) begin
            crop_size <= CROP_LINES;
        end else begin
            crop_size <= '0;
        end
    end

endmodule

/* source/frame_top.sv */
//**********************************************************
// Frame wrapper glue top level. Connects the OSD decode,
// user port, mouse decode and vertical crop blocks
//**********************************************************
`timescale 1ns/1ps

module frame_top #(
    parameter bit ROTATE_MENU = 1'b0,
    parameter bit OSD_60HZ    = 1'b0
) (
    input  logic                    clk_sys,
    input  logic                    rst,
    // OSD and host side
    input  frame_pkg::status_t      status,
    input  frame_pkg::core_mod_t    core_mod,
    input  logic                    direct_video,
    input  logic [1:0]              osd_rotate,
    input  frame_pkg::hdmi_dim_t    hdmi_width,
    input  frame_pkg::hdmi_dim_t    hdmi_height,
    output frame_pkg::menumask_t    menumask,
    output logic                    framebuf_flip,
    output logic                    hsize_enable,
    output logic [3:0]              hsize_scale,
    output logic [3:0]              hoffset,
    output logic [3:0]              voffset,
    // Extension port
    input  frame_pkg::user_pin_t    user_in,
    input  frame_pkg::user_pin_t    joy_out,
    input  logic                    game_tx,
    input  logic                    uart_tx,
    output frame_pkg::user_pin_t    user_out,
    output logic                    game_rx,
    output logic                    db15_en,
    output logic                    uart_en,
    // Mouse
    input  frame_pkg::mouse_pkt_t   ps2_mouse,
    output logic                    mouse_st,
    output frame_pkg::mouse_delta_t mouse_dx,
    output frame_pkg::mouse_delta_t mouse_dy,
    output frame_pkg::mouse_flags_t mouse_flags,
    // Vertical crop
    output logic                    crop_ok,
    output frame_pkg::crop_size_t   crop_size,
    output frame_pkg::crop_off_t    crop_off
);
    import frame_pkg::*;

    logic        crop_en;
    logic        scanline_fx;
    logic        force_scan2x;
    vcopt_t      vcopt;
    crop_scale_t crop_scale;

    osd_config #(
        .ROTATE_MENU (ROTATE_MENU),
        .OSD_60HZ    (OSD_60HZ)
    ) u_osd (
        .clk_sys       (clk_sys),
        .rst           (rst),
        .status        (status),
        .core_mod      (core_mod),
        .direct_video  (direct_video),
        .crop_ok       (crop_ok),
        .menumask      (menumask),
        .framebuf_flip (framebuf_flip),
        .db15_en       (db15_en),
        .uart_en       (uart_en),
        .crop_en       (crop_en),
        .vcopt         (vcopt),
        .crop_scale    (crop_scale),
        .scanline_fx   (scanline_fx),
        .force_scan2x  (force_scan2x),
        .hsize_enable  (hsize_enable),
        .hsize_scale   (hsize_scale),
        .hoffset       (hoffset),
        .voffset       (voffset)
    );

    user_port u_user (
        .clk_sys  (clk_sys),
        .rst      (rst),
        .db15_en  (db15_en),
        .uart_en  (uart_en),
        .user_in  (user_in),
        .joy_out  (joy_out),
        .game_tx  (game_tx),
        .uart_tx  (uart_tx),
        .user_out (user_out),
        .game_rx  (game_rx)
    );

    mouse_decode u_mouse (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .ps2_mouse   (ps2_mouse),
        .mouse_st    (mouse_st),
        .mouse_dx    (mouse_dx),
        .mouse_dy    (mouse_dy),
        .mouse_flags (mouse_flags)
    );

    crop_ctrl u_crop (
        .clk_sys      (clk_sys),
        .rst          (rst),
        .hdmi_width   (hdmi_width),
        .hdmi_height  (hdmi_height),
        .scanline_fx  (scanline_fx),
        .force_scan2x (force_scan2x),
        .crop_scale   (crop_scale),
        .direct_video (direct_video),
        .osd_rotate   (osd_rotate),
        .crop_en      (crop_en),
        .vcopt        (vcopt),
        .crop_ok      (crop_ok),
        .crop_size    (crop_size),
        .crop_off     (crop_off)
    );

endmodule

/* bench/frame_asserts.sv */
//**********************************************************
// Concurrent checks on the frame glue top level, bound into
// frame_top by the testbench
//**********************************************************
`timescale 1ns/1ps

module frame_asserts (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  logic                  mouse_st,
    input  logic                  crop_ok,
    input  frame_pkg::crop_size_t crop_size,
    input  frame_pkg::user_pin_t  user_out,
    input  logic                  db15_en,
    input  logic                  uart_en
);
    import frame_pkg::*;

    // Assertion failures so far
    int fail_count = 0;

    // One strobe cycle per packet
    mouse_strobe_single: assert property (
        @(posedge clk_sys) disable iff (rst)
        mouse_st |=> !mouse_st
    ) else begin
        fail_count++;
        $error("mouse_st high on two consecutive cycles");
    end

    // Crop is off, or 216 lines behind a crop_ok one cycle earlier
    crop_size_legal: assert property (
        @(posedge clk_sys) disable iff (rst)
        (crop_size == '0) || ((crop_size == CROP_LINES) && $past(crop_ok))
    ) else begin
        fail_count++;
        $error("crop_size %0d is not 0, or 216 without crop_ok", crop_size);
    end

    // Port idles high once both users let go
    user_port_idle: assert property (
        @(posedge clk_sys) disable iff (rst)
        (!db15_en && !uart_en) |=> (user_out == '1)
    ) else begin
        fail_count++;
        $error("user_out 0x%0h not idle after both enables low", user_out);
    end

endmodule

/* bench/frame_tb.sv */
//**********************************************************
// Directed testbench for the frame glue top level, run from
// the project root through tb.f
//**********************************************************
`timescale 1ns/1ps

module frame_tb;
    import frame_pkg::*;

    localparam bit ROTATE_MENU = 1'b0;
    localparam bit OSD_60HZ    = 1'b1;
    localparam int SEED        = 32'h5f35b3b1;
    // Tests take about 250 cycles, so this leaves a wide margin
    localparam int MAX_CYCLES  = 4000;

    logic         clk_sys = 1'b0;
    logic         rst;
    status_t      status;
    core_mod_t    core_mod;
    logic         direct_video;
    logic [1:0]   osd_rotate;
    hdmi_dim_t    hdmi_width;
    hdmi_dim_t    hdmi_height;
    menumask_t    menumask;
    logic         framebuf_flip;
    logic         hsize_enable;
    logic [3:0]   hsize_scale;
    logic [3:0]   hoffset;
    logic [3:0]   voffset;
    user_pin_t    user_in;
    user_pin_t    joy_out;
    logic         game_tx;
    logic         uart_tx;
    user_pin_t    user_out;
    logic         game_rx;
    logic         db15_en;
    logic         uart_en;
    mouse_pkt_t   ps2_mouse;
    logic         mouse_st;
    mouse_delta_t mouse_dx;
    mouse_delta_t mouse_dy;
    mouse_flags_t mouse_flags;
    logic         crop_ok;
    crop_size_t   crop_size;
    crop_off_t    crop_off;

    int errors       = 0;
    int assert_fails = 0;
    int tests_run    = 0;
    int cycle_count  = 0;

    frame_top #(
        .ROTATE_MENU (ROTATE_MENU),
        .OSD_60HZ    (OSD_60HZ)
    ) frame_top_i (.*);

    bind frame_top frame_asserts u_asserts (
        .clk_sys   (clk_sys),
        .rst       (rst),
        .mouse_st  (mouse_st),
        .crop_ok   (crop_ok),
        .crop_size (crop_size),
        .user_out  (user_out),
        .db15_en   (db15_en),
        .uart_en   (uart_en)
    );

    always #2 clk_sys = ~clk_sys;

    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic log_fail(input string test_name, input logic [63:0] exp_val,
                            input logic [63:0] act_val);
        errors++;
        $display("Fail %s: expected 0x%0h, actual 0x%0h", test_name, exp_val, act_val);
    endtask

    // Plain 1080p output with every crop blocker clear, called at a rising edge
    task automatic drive_idle();
        status       <= '0;
        core_mod     <= '0;
        direct_video <= 1'b0;
        osd_rotate   <= 2'b00;
        hdmi_width   <= HDMI_FULL_W;
        hdmi_height  <= HDMI_FULL_H;
        user_in      <= '1;
        joy_out      <= '1;
        game_tx      <= 1'b1;
        uart_tx      <= 1'b1;
    endtask

    task automatic check_reset_state();
        tests_run++;
        @(negedge clk_sys);
        if (mouse_st !== 1'b0) log_fail("reset mouse_st", 64'(0), 64'(mouse_st));
        if (framebuf_flip !== 1'b0) log_fail("reset framebuf_flip", 64'(0), 64'(framebuf_flip));
        if (crop_ok !== 1'b0) log_fail("reset crop_ok", 64'(0), 64'(crop_ok));
        if (crop_size !== '0) log_fail("reset crop_size", 64'(0), 64'(crop_size));
        if (user_out !== 7'h7f) log_fail("reset user_out", 64'(7'h7f), 64'(user_out));
    endtask

    task automatic exercise_user_port();
        status_t   st;
        user_pin_t jo;
        user_pin_t ui;
        logic      gt;
        logic      ut;
        user_pin_t exp_out;
        logic      exp_rx;
        tests_run++;
        for (int i = 0; i < 16; i++) begin
            jo = user_pin_t'($urandom);
            ui = user_pin_t'($urandom);
            gt = 1'($urandom);
            ut = 1'($urandom);
            st = '0;
            st[ST_DB15] = i[0];
            st[ST_UART] = i[1];
            @(posedge clk_sys);
            status  <= st;
            joy_out <= jo;
            user_in <= ui;
            game_tx <= gt;
            uart_tx <= ut;
            // DB15 wins, then the UART with pin 0 as a shared low-wins line
            if (st[ST_DB15]) begin
                exp_out = jo;
            end else if (st[ST_UART]) begin
                exp_out = {6'h3f, gt & ut};
            end else begin
                exp_out = 7'h7f;
            end
            exp_rx = st[ST_UART] ? ui[1] : 1'b1;
            @(negedge clk_sys);
            if (game_rx !== exp_rx) log_fail("user_port game_rx", 64'(exp_rx), 64'(game_rx));
            if (db15_en !== st[37]) log_fail("user_port db15_en", 64'(st[37]), 64'(db15_en));
            if (uart_en !== st[38]) log_fail("user_port uart_en", 64'(st[38]), 64'(uart_en));
            @(negedge clk_sys);
            if (user_out !== exp_out) log_fail("user_port user_out", 64'(exp_out), 64'(user_out));
        end
    endtask

    task automatic send_mouse_packets();
        mouse_pkt_t pkt;
        logic       tog;
        logic       flip;
        int         exp_dx;
        int         exp_dy;
        tests_run++;
        tog = ps2_mouse[24];
        for (int i = 0; i < 12; i++) begin
            flip = (i % 4) != 3;
            pkt[23:0] = 24'($urandom);
            pkt[24] = flip ? !tog : tog;
            tog = pkt[24];
            @(posedge clk_sys);
            ps2_mouse <= pkt;
            @(posedge clk_sys);
            @(negedge clk_sys);
            if (mouse_st !== 1'b0) log_fail("mouse early strobe", 64'(0), 64'(mouse_st));
            @(posedge clk_sys);
            @(negedge clk_sys);
            if (mouse_st !== flip) log_fail("mouse strobe", 64'(flip), 64'(mouse_st));
            if (flip) begin
                // 9-bit two's complement, sign taken from the flag byte
                exp_dx = pkt[4] ? int'(pkt[15:8]) - 256 : int'(pkt[15:8]);
                exp_dy = pkt[5] ? int'(pkt[23:16]) - 256 : int'(pkt[23:16]);
                if (int'(mouse_dx) != exp_dx) log_fail("mouse dx", 64'(exp_dx), 64'(mouse_dx));
                if (int'(mouse_dy) != exp_dy) log_fail("mouse dy", 64'(exp_dy), 64'(mouse_dy));
                if (mouse_flags !== pkt[7:0]) begin
                    log_fail("mouse flags", 64'(pkt[7:0]), 64'(mouse_flags));
                end
            end
        end
    endtask

    task automatic sweep_crop_offset();
        status_t    st;
        int         exp_off;
        crop_size_t exp_size;
        tests_run++;
        for (int v = 0; v < 16; v++) begin
            st = '0;
            st[ST_VCOPT_LO +: 4] = 4'(v);
            @(posedge clk_sys);
            drive_idle();
            status <= st;
            @(posedge clk_sys);
            @(negedge clk_sys);
            exp_off = (v >= int'(VCOPT_WRAP)) ? 2 * v - 24 : 2 * v;
            if (crop_off !== crop_off_t'(exp_off)) begin
                log_fail("crop offset", 64'(exp_off), 64'(crop_off));
            end
        end
        for (int n = 0; n < 6; n++) begin
            st = '0;
            st[ST_CROP_EN] = !n[0];
            @(posedge clk_sys);
            status <= st;
            repeat (2) @(posedge clk_sys);
            @(negedge clk_sys);
            exp_size = st[ST_CROP_EN] ? CROP_LINES : crop_size_t'(0);
            if (crop_size !== exp_size) log_fail("crop size", 64'(exp_size), 64'(crop_size));
        end
    endtask

    task automatic block_crop_conditions();
        status_t st;
        tests_run++;
        for (int c = 0; c < 7; c++) begin
            st = '0;
            st[ST_CROP_EN] = 1'b1;
            @(posedge clk_sys);
            drive_idle();
            status <= st;
            repeat (2) @(posedge clk_sys);
            @(negedge clk_sys);
            if (crop_size !== CROP_LINES) log_fail("crop block setup", 64'(216), 64'(crop_size));
            @(posedge clk_sys);
            case (c)
                0: hdmi_width <= 12'd1280;
                1: hdmi_height <= 12'd720;
                2: st[ST_SCANLINE_LO +: 3] = 3'(1 + $urandom % 7);
                3: st[ST_FORCE_SCAN2X] = 1'b1;
                4: st[ST_SCALE_LO +: 2] = 2'(1 + $urandom % 3);
                5: direct_video <= 1'b1;
                default: osd_rotate <= 2'b01;
            endcase
            status <= st;
            repeat (2) @(posedge clk_sys);
            @(negedge clk_sys);
            if (crop_ok !== 1'b0) begin
                log_fail($sformatf("crop block %0d ok", c), 64'(0), 64'(crop_ok));
            end
            if (crop_size !== '0) begin
                log_fail($sformatf("crop block %0d size", c), 64'(0), 64'(crop_size));
            end
        end
    endtask

    function automatic menumask_t expected_menumask(input status_t st, input core_mod_t cm,
                                                    input logic dv, input logic ok);
        menumask_t m;
        m = '0;
        m[5] = ok;
        m[4] = ROTATE_MENU ? !cm[0] : 1'b1;
        m[3] = OSD_60HZ ? st[ST_60HZ] : 1'b1;
        m[2] = !st[ST_HSIZE_EN];
        m[1] = ROTATE_MENU ? 1'b1 : !cm[0];
        m[0] = dv;
        return m;
    endfunction

    task automatic verify_menu_mask();
        status_t    st;
        core_mod_t  cm;
        logic       dv;
        logic [1:0] rot;
        hdmi_dim_t  w;
        logic       exp_ok;
        logic       exp_flip;
        logic       prev_flip;
        menumask_t  exp_mask;
        tests_run++;
        prev_flip = status[ST_FLIP_LO +: 2] == 2'b10;
        for (int i = 0; i < 24; i++) begin
            st  = {$urandom, $urandom};
            cm  = core_mod_t'($urandom);
            dv  = 1'($urandom);
            rot = 2'($urandom);
            w   = (i % 5 == 3) ? 12'd1280 : HDMI_FULL_W;
            // Odd rounds clear the blockers so crop_ok can rise
            if (i[0]) begin
                st[ST_SCANLINE_HI:ST_SCANLINE_LO] = '0;
                st[ST_FORCE_SCAN2X] = 1'b0;
                st[ST_SCALE_LO +: 2] = '0;
                dv = 1'b0;
                rot[0] = 1'b0;
            end
            exp_ok = (w == HDMI_FULL_W) && (st[5:3] == '0) && !st[63] && (st[47:46] == '0)
                     && !dv && !rot[0];
            exp_flip = st[39:38] == 2'b10;
            exp_mask = expected_menumask(st, cm, dv, exp_ok);
            @(posedge clk_sys);
            status       <= st;
            core_mod     <= cm;
            direct_video <= dv;
            osd_rotate   <= rot;
            hdmi_width   <= w;
            hdmi_height  <= HDMI_FULL_H;
            @(negedge clk_sys);
            if (framebuf_flip !== prev_flip) begin
                log_fail("flip hold", 64'(prev_flip), 64'(framebuf_flip));
            end
            @(negedge clk_sys);
            if (framebuf_flip !== exp_flip) log_fail("flip", 64'(exp_flip), 64'(framebuf_flip));
            if (crop_ok !== exp_ok) log_fail("menu crop_ok", 64'(exp_ok), 64'(crop_ok));
            for (int b = 0; b < 16; b++) begin
                if (menumask[b] !== exp_mask[b]) begin
                    log_fail($sformatf("menu mask bit %0d", b), 64'(exp_mask[b]),
                             64'(menumask[b]));
                end
            end
            // Horizontal size and offset fields
            if (hsize_enable !== st[48]) begin
                log_fail("hsize enable", 64'(st[48]), 64'(hsize_enable));
            end
            if (hsize_scale !== st[52:49]) begin
                log_fail("hsize scale", 64'(st[52:49]), 64'(hsize_scale));
            end
            if (hoffset !== st[56:53]) log_fail("hoffset", 64'(st[56:53]), 64'(hoffset));
            if (voffset !== st[60:57]) log_fail("voffset", 64'(st[60:57]), 64'(voffset));
            prev_flip = exp_flip;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst          = 1'b1;
        status       = '0;
        core_mod     = '0;
        direct_video = 1'b0;
        osd_rotate   = 2'b00;
        hdmi_width   = HDMI_FULL_W;
        hdmi_height  = HDMI_FULL_H;
        user_in      = '1;
        joy_out      = '1;
        game_tx      = 1'b1;
        uart_tx      = 1'b1;
        ps2_mouse    = '0;
        repeat (3) @(posedge clk_sys);
        rst <= 1'b0;
        check_reset_state();
        exercise_user_port();
        send_mouse_packets();
        sweep_crop_offset();
        block_crop_conditions();
        verify_menu_mask();
        assert_fails = frame_top_i.u_asserts.fail_count;
        $display("Tests run: %0d, errors: %0d, assertion failures: %0d",
                 tests_run, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* tb.f */
source/frame_pkg.sv
source/osd_config.sv
source/user_port.sv
source/mouse_decode.sv
source/crop_ctrl.sv
source/frame_top.sv
bench/frame_asserts.sv
bench/frame_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the frame glue testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module frame_tb -o frame_sim

output=$(./obj_dir/frame_sim) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
